// File: Bender.yml
package:
  name: dz_display

dependencies: {}

sources:
  # package first, then the blocks, then the top level
  - source/dz_pkg.sv
  - source/stage_sequencer.sv
  - source/frame_buffer.sv
  - source/matrix_scan.sv
  - source/dz_display_top.sv

  - target: test
    files:
      - verification/dz_display_tb.sv

// File: source/dz_display_top.sv
`timescale 1ns/1ns

module dz_display_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             st,
    input  logic             step,
    input  logic             temp,
    output dz_pkg::col_bits_t row,
    output dz_pkg::col_bits_t colg,
    output dz_pkg::col_bits_t colr
);

    import dz_pkg::*;

    stage_e     stage;
    scan_line_t line;
    logic       blank;

    stage_sequencer u_seq (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .step  (step),
        .stage (stage)
    );

    // glyph lookup and row scan
    frame_buffer u_fb (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .stage (stage),
        .line  (line),
        .blank (blank)
    );

    matrix_scan u_scan (
        .clk   (clk),
        .rst   (rst),
        .temp  (temp),
        .line  (line),
        .blank (blank),
        .row   (row),
        .colg  (colg),
        .colr  (colr)
    );

endmodule

// File: source/dz_pkg.sv
package dz_pkg;

    localparam int matrix_rows = 8;
    localparam int matrix_cols = 8;
    localparam int stage_count = 12;

    typedef logic [$clog2(matrix_rows)-1:0] row_idx_t;
    typedef logic [matrix_cols-1:0]         col_bits_t;    // bit 7 is the leftmost led

    // picture stages in step order
    typedef enum logic [3:0] {
        ring_1,
        ring_2,
        ring_3,
        ring_4,
        ring_5,
        full,
        wave_a,
        wave_b,
        spiral,
        flame,
        drop,
        ember
    } stage_e;

    typedef struct packed {
        row_idx_t  row;
        col_bits_t green;
    } scan_line_t;

    // green pattern per stage, rows 0 to 7
    localparam col_bits_t glyph_table [stage_count][matrix_rows] = '{
        // growing rings
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0011_1100, 8'b0001_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1000, 8'b0111_1100,
          8'b0111_1100, 8'b0011_1000, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0000_0000, 8'b0011_1100, 8'b0111_1110,
          8'b0111_1110, 8'b0011_1100, 8'b0000_0000, 8'b0000_0000},
        '{8'b0000_0000, 8'b0011_1100, 8'b0111_1110, 8'b0111_1110,
          8'b0111_1110, 8'b0111_1110, 8'b0011_1100, 8'b0000_0000},
        '{8'b0011_1100, 8'b0111_1110, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b0111_1110, 8'b0011_1100},
        // full
        '{8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111,
          8'b1111_1111, 8'b1111_1111, 8'b1111_1111, 8'b1111_1111},
        // wave_a, wave_b
        '{8'b1100_0011, 8'b1110_0011, 8'b1111_0001, 8'b1110_0011,
          8'b1100_0111, 8'b1110_0111, 8'b1111_0111, 8'b1111_1011},
        '{8'b0000_0000, 8'b0000_0001, 8'b1000_0001, 8'b1100_0011,
          8'b1000_0011, 8'b1100_0111, 8'b1110_0111, 8'b1111_0011},
        // spiral
        '{8'b0000_0000, 8'b0011_1000, 8'b0100_0100, 8'b0101_1010,
          8'b0100_1010, 8'b0011_0010, 8'b1100_0100, 8'b0011_1000},
        // flame
        '{8'b0000_0000, 8'b0000_0000, 8'b0110_0000, 8'b1111_1100,
          8'b0011_1111, 8'b0011_1110, 8'b0001_1100, 8'b0000_0000},
        // drop
        '{8'b0000_0000, 8'b0000_0000, 8'b0001_1000, 8'b0011_1100,
          8'b0111_1110, 8'b0111_1110, 8'b0010_0100, 8'b0000_0000},
        // ember, top left corner only
        '{8'b1110_0000, 8'b0110_0000, 8'b0000_0000, 8'b0000_0000,
          8'b0000_0000, 8'b0000_0000, 8'b0000_0000, 8'b0000_0000}
    };

endpackage

// File: source/frame_buffer.sv
`timescale 1ns/1ns

module frame_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  dz_pkg::stage_e     stage,
    output dz_pkg::scan_line_t line,
    output logic              blank
);

    import dz_pkg::*;

    localparam row_idx_t last_row = row_idx_t'(matrix_rows - 1);

    row_idx_t   row_cnt;
    logic       frame_end;
    stage_e     shown_stage;
    col_bits_t  green_lookup;
    scan_line_t line_next;
    scan_line_t line_q;
    logic       blank_q;

    assign frame_end = (row_cnt == last_row);

    // row scan counter, one row per clock
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= '0;
        end
        else if (frame_end)
        begin
            row_cnt <= '0;
        end
        else
        begin
            row_cnt <= row_cnt + row_idx_t'(1);
        end
    end

    // picture only changes between frames
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            shown_stage <= ring_1;
        end
        else if (frame_end)
        begin
            shown_stage <= stage;
        end
    end

    function automatic col_bits_t glyph_row(input stage_e s, input row_idx_t r);
        col_bits_t bits;
        if (int'(s) < stage_count)
        begin
            bits = glyph_table[s][r];
        end
        else
        begin
            bits = '0;    // unused encodings stay dark
        end
        return bits;
    endfunction

    assign green_lookup = glyph_row(shown_stage, row_cnt);

    always_comb
    begin
        line_next.row   = row_cnt;
        line_next.green = green_lookup;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            line_q <= '0;
        end
        else
        begin
            line_q <= line_next;
        end
    end

    // blank follows st, aligned with the line register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            blank_q <= 1'b1;
        end
        else
        begin
            blank_q <= ~st;
        end
    end

    assign line  = line_q;
    assign blank = blank_q;

endmodule

// File: source/matrix_scan.sv
`timescale 1ns/1ns

module matrix_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              temp,
    input  dz_pkg::scan_line_t line,
    input  logic              blank,
    output dz_pkg::col_bits_t  row,
    output dz_pkg::col_bits_t  colg,
    output dz_pkg::col_bits_t  colr
);

    import dz_pkg::*;

    col_bits_t row_sel;
    col_bits_t green_gated;
    col_bits_t red_next;
    col_bits_t row_q;
    col_bits_t colg_q;
    col_bits_t colr_q;

    // one-cold row select, low bit is row 0
    function automatic col_bits_t row_decode(input row_idx_t r);
        col_bits_t sel;
        sel = '1;
        sel[r] = 1'b0;
        return sel;
    endfunction

    assign row_sel = row_decode(line.row);

    always_comb
    begin
        green_gated = blank ? '0 : line.green;
        red_next    = temp ? green_gated : '0;    // red overlays the green leds
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_q  <= '1;    // all rows off
            colg_q <= '0;
            colr_q <= '0;
        end
        else
        begin
            row_q  <= row_sel;
            colg_q <= green_gated;
            colr_q <= red_next;
        end
    end

    assign row  = row_q;
    assign colg = colg_q;
    assign colr = colr_q;

endmodule

// File: source/stage_sequencer.sv
`timescale 1ns/1ns

module stage_sequencer (
    input  logic          clk,
    input  logic          rst,
    input  logic          st,
    input  logic          step,
    output dz_pkg::stage_e stage
);

    import dz_pkg::*;

    stage_e stage_q;
    stage_e stage_next;

    // successor in step order, ember wraps
    function automatic stage_e succ(input stage_e s);
        stage_e n;
        if (s == ember)
        begin
            n = ring_1;
        end
        else
        begin
            n = stage_e'(s + 4'd1);
        end
        return n;
    endfunction

    always_comb
    begin
        stage_next = stage_q;
        if (!st)
        begin
            stage_next = ring_1;    // held at the first picture
        end
        else if (step)
        begin
            stage_next = succ(stage_q);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stage_q <= ring_1;
        end
        else
        begin
            stage_q <= stage_next;
        end
    end

    assign stage = stage_q;

endmodule

// File: sources.f
source/dz_pkg.sv
source/stage_sequencer.sv
source/frame_buffer.sv
source/matrix_scan.sv
source/dz_display_top.sv
verification/dz_display_tb.sv

// File: verification/dz_display_cases.txt
# name st temp steps expected_stage
# expected_stage counts from 0 (ring_1) to 11 (ember)
blank_after_reset 0 0 0 0
blank_with_red 0 1 0 0
show_ring_1 1 0 0 0
step_01_ring_2 1 0 1 1
step_02_ring_3 1 0 2 2
step_03_ring_4 1 0 3 3
step_04_ring_5 1 0 4 4
step_05_full 1 0 5 5
step_06_wave_a 1 0 6 6
step_07_wave_b 1 0 7 7
step_08_spiral 1 0 8 8
step_09_flame 1 0 9 9
step_10_drop 1 0 10 10
step_11_ember 1 0 11 11
wrap_12_ring_1 1 0 12 0
wrap_13_ring_2 1 0 13 1
red_ring_1 1 1 0 0
red_ring_3 1 1 2 2
red_full 1 1 5 5
red_wave_a 1 1 6 6
red_wave_b 1 1 7 7
red_spiral 1 1 8 8
red_flame 1 1 9 9
red_drop 1 1 10 10
red_ember 1 1 11 11
red_wrap_ring_1 1 1 12 0
green_only_full 1 0 5 5
st_low_ignores_3 0 0 3 0
st_low_ignores_7 0 1 7 0
restart_after_low 1 0 0 0
hold_ember 1 0 11 11
restart_after_ember 1 0 0 0
hold_flame_red 1 1 9 9
restart_red_ring_1 1 1 0 0
long_run_17_full 1 1 17 5
long_run_24_ring_1 1 0 24 0
long_run_23_ember 1 0 23 11
st_low_after_ember 0 0 11 0
one_step_again 1 1 1 1
two_steps_again 1 0 2 2
st_low_ignores_1 0 1 1 0
final_ring_1 1 0 0 0

// File: verification/dz_display_tb.sv
`timescale 1ns/1ns

module dz_display_tb;

    import dz_pkg::*;

    localparam int wait_limit = 100;    // clocks per wait loop

    logic      clk;
    logic      rst;
    logic      st;
    logic      step;
    logic      temp;
    col_bits_t row;
    col_bits_t colg;
    col_bits_t colr;

    col_bits_t cap_row [matrix_rows];
    col_bits_t cap_g [matrix_rows];
    col_bits_t cap_r [matrix_rows];

    string       cur_name;
    int          case_errors;
    int          pass_count;
    int          fail_count;

    dz_display_top UUT (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .step (step),
        .temp (temp),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_bits(input string what, input string unit, input int n,
                              input col_bits_t exp, input col_bits_t act);
        assert (act === exp)
        else
        begin
            $display("[FAIL] %s %s %s %0d: expected %b, actual %b",
                     cur_name, what, unit, n, exp, act);
            case_errors++;
        end
    endtask

    task automatic finish_test;
        if (case_errors == 0)
        begin
            $display("test %s: ok", cur_name);
            pass_count++;
        end
        else
        begin
            $display("test %s: %0d mismatches", cur_name, case_errors);
            fail_count++;
        end
        case_errors = 0;
    endtask

    // position of the single low bit, -1 if not exactly one
    function automatic int zero_position(input col_bits_t sel);
        int pos;
        int zeros;
        pos   = -1;
        zeros = 0;
        for (int b = 0; b < matrix_cols; b++)
        begin
            if (sel[b] === 1'b0)
            begin
                zeros++;
                pos = b;
            end
        end
        if (zeros != 1)
        begin
            pos = -1;
        end
        return pos;
    endfunction

    // returns at the negedge where row 0 is selected
    task automatic wait_frame_start;
        int n;
        @(negedge clk);
        n = 0;
        while (row[0] === 1'b0 && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (row[0] === 1'b0)
        begin
            abort_run("timeout: row select stayed on row 0");
        end
        n = 0;
        while (row[0] !== 1'b0 && n < wait_limit)
        begin
            @(negedge clk);
            n++;
        end
        if (row[0] !== 1'b0)
        begin
            abort_run("timeout: row select never reached row 0");
        end
    endtask

    // samples from the current negedge on, optional step pulse mid frame
    task automatic capture_frame(input int pulse_row);
        for (int i = 0; i < matrix_rows; i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
            end
            cap_row[i] = row;
            cap_g[i]   = colg;
            cap_r[i]   = colr;
            if (i == pulse_row)
            begin
                @(posedge clk);
                step <= 1'b1;
            end
            else if (i == pulse_row + 1)
            begin
                @(posedge clk);
                step <= 1'b0;
            end
        end
    endtask

    task automatic check_frame(input int exp_stage, input int st_v, input int temp_v);
        int        idx;
        col_bits_t exp_g;
        col_bits_t exp_r;
        for (int i = 0; i < matrix_rows; i++)
        begin
            idx = zero_position(cap_row[i]);
            assert (idx == i)
            else
            begin
                $display("[FAIL] %s row index %0d: expected %0d, actual %0d (select %b)",
                         cur_name, i, i, idx, cap_row[i]);
                case_errors++;
            end
            exp_g = (st_v != 0) ? glyph_table[exp_stage][i] : '0;
            exp_r = (temp_v != 0) ? exp_g : '0;
            check_bits("colg", "row", i, exp_g, cap_g[i]);
            check_bits("colr", "row", i, exp_r, cap_r[i]);
        end
    endtask

    function automatic bit frame_matches(input int s);
        bit same;
        same = 1'b1;
        for (int i = 0; i < matrix_rows; i++)
        begin
            if (cap_g[i] !== glyph_table[s][i])
            begin
                same = 1'b0;
            end
        end
        return same;
    endfunction

    task automatic run_case(input int st_v, input int temp_v, input int steps_v,
                            input int exp_v);
        int idle;
        if (exp_v < 0 || exp_v >= stage_count)
        begin
            abort_run("cases file holds an expected stage out of range");
        end
        @(posedge clk);    // st low returns the sequencer to ring_1
        st   <= 1'b0;
        step <= 1'b0;
        temp <= temp_v[0];
        @(posedge clk);
        @(posedge clk);
        st <= st_v[0];
        for (int i = 0; i < steps_v; i++)
        begin
            idle = 1 + ($urandom % 4);
            repeat (idle) @(posedge clk);
            step <= 1'b1;
            @(posedge clk);
            step <= 1'b0;
        end
        wait_frame_start();
        wait_frame_start();
        capture_frame(-1);
        check_frame(exp_v, st_v, temp_v);
    endtask

    // step lands at row 3, ring_5 to full
    task automatic run_integrity_test;
        bit m_old;
        bit m_new;
        cur_name = "frame_integrity";
        run_case(1, 1, 4, 4);
        for (int f = 0; f < 3; f++)
        begin
            @(negedge clk);    // row 0 of the next frame
            capture_frame(f == 0 ? 3 : -1);
            m_old = frame_matches(4);
            m_new = frame_matches(5);
            assert (m_old != m_new)
            else
            begin
                $display("[FAIL] %s frame %0d: expected one stage (4 or 5), actual old %0d new %0d",
                         cur_name, f, m_old, m_new);
                case_errors++;
            end
        end
        check_frame(5, 1, 1);
        finish_test();
    endtask

    initial
    begin
        int    fd;
        int    code;
        bit    reading_done;
        string tok;
        int    st_v;
        int    temp_v;
        int    steps_v;
        int    exp_v;
        int    ch;

        rst         = 1'b1;
        st          = 1'b0;
        step        = 1'b0;
        temp        = 1'b0;
        case_errors = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(13024));

        cur_name = "reset_state";
        for (int c = 0; c < 3; c++)
        begin
            @(posedge clk);
            @(negedge clk);
            check_bits("row", "cycle", c, 8'hff, row);
            check_bits("colg", "cycle", c, 8'h00, colg);
            check_bits("colr", "cycle", c, 8'h00, colr);
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bits("row", "cycle", 3, 8'hff, row);
        check_bits("colg", "cycle", 3, 8'h00, colg);
        check_bits("colr", "cycle", 3, 8'h00, colr);
        finish_test();

        fd = $fopen("verification/dz_display_cases.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open verification/dz_display_cases.txt");
        end
        reading_done = 1'b0;
        while (!reading_done)
        begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1)
            begin
                reading_done = 1'b1;
            end
            else if (tok[0] == "#")
            begin
                ch = $fgetc(fd);    // drop the rest of the comment line
                while (ch != 10 && ch != -1)
                begin
                    ch = $fgetc(fd);
                end
            end
            else
            begin
                code = $fscanf(fd, "%d %d %d %d", st_v, temp_v, steps_v, exp_v);
                if (code != 4)
                begin
                    abort_run("malformed line in the cases file");
                end
                cur_name = tok;
                run_case(st_v, temp_v, steps_v, exp_v);
                finish_test();
            end
        end
        $fclose(fd);

        run_integrity_test();

        $display("tests: %0d run, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
